//--- sipo_pkg.sv
`default_nettype none

package sipo_pkg;

    // frame geometry
    localparam int count_w      = 20;
    localparam int last_count   = 13;               // counter value that ends logging
    localparam int frame_bits   = last_count - 1;   // bits per lane per frame
    localparam int n_lanes      = 4;
    localparam int frame_cycles = 17;               // clear, idle, arm, 12 log, 2 ready
    localparam int seq_w        = 8;

    // counter select, as the sequencer drives it
    typedef enum logic [1:0] {
        cnt_hold_idle = 2'b00,
        cnt_clear     = 2'b01,  // decoded by the counter, never driven
        cnt_hold_done = 2'b10,
        cnt_count     = 2'b11
    } cnt_sel_t;

    typedef enum logic [3:0] {
        s_clear = 4'd0,
        s_idle  = 4'd1,
        s_arm   = 4'd2,
        s_log   = 4'd3,
        s_ready = 4'd4
    } ctrl_state_t;

    typedef logic [frame_bits-1:0] lane_word_t;

    // lane 0 sits in the low bits of words
    typedef struct packed {
        logic [seq_w-1:0]                seq;
        lane_word_t [n_lanes-1:0]        words;
    } frame_t;

endpackage

`default_nettype wire

//--- bit_counter.sv
`timescale 1ns/1ps
`default_nettype none

module bit_counter (
    input  logic                           clk,
    input  logic                           reset_b,
    input  sipo_pkg::cnt_sel_t             counter_sel,
    input  logic                           control_signal,
    output logic [sipo_pkg::count_w-1:0]   counter_value
);

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
            counter_value <= '0;
        else if (control_signal || counter_sel == sipo_pkg::cnt_clear)
            counter_value <= '0;
        else if (counter_sel == sipo_pkg::cnt_count)
            counter_value <= counter_value + 1'b1;
    end

    // sequencer must switch to hold as soon as the last count shows
    a_no_step_past_last: assert property (@(posedge clk) disable iff (!reset_b)
        (counter_value == sipo_pkg::count_w'(sipo_pkg::last_count))
            |=> (counter_value != sipo_pkg::count_w'(sipo_pkg::last_count + 1)));

endmodule

`default_nettype wire

//--- sipo_controller.sv
`timescale 1ns/1ps
`default_nettype none

module sipo_controller (
    input  logic                           clk,
    input  logic                           reset_b,
    input  logic [sipo_pkg::count_w-1:0]   counter_value,
    output sipo_pkg::cnt_sel_t             counter_sel,
    output logic                           control_signal,
    output logic                           data_logging,
    output logic                           data_ready
);

    sipo_pkg::ctrl_state_t state;
    sipo_pkg::ctrl_state_t next_state;

    logic at_last;

    assign at_last = (counter_value == sipo_pkg::count_w'(sipo_pkg::last_count));

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
            state <= sipo_pkg::s_clear;
        else
            state <= next_state;
    end

    always_comb
    begin
        counter_sel    = sipo_pkg::cnt_hold_idle;
        control_signal = 1'b0;
        data_logging   = 1'b0;
        data_ready     = 1'b0;
        next_state     = sipo_pkg::s_clear;
        case (state)
            sipo_pkg::s_clear:
            begin
                control_signal = 1'b1;   // counter back to zero
                next_state     = sipo_pkg::s_idle;
            end
            sipo_pkg::s_idle:
            begin
                next_state = sipo_pkg::s_arm;
            end
            sipo_pkg::s_arm:
            begin
                counter_sel = sipo_pkg::cnt_count;
                next_state  = sipo_pkg::s_log;
            end
            sipo_pkg::s_log:
            begin
                if (at_last)
                begin
                    // stop the count here, hold through ready
                    counter_sel = sipo_pkg::cnt_hold_done;
                    data_ready  = 1'b1;
                    next_state  = sipo_pkg::s_ready;
                end
                else
                begin
                    counter_sel  = sipo_pkg::cnt_count;
                    data_logging = 1'b1;
                    next_state   = sipo_pkg::s_log;
                end
            end
            sipo_pkg::s_ready:
            begin
                counter_sel = sipo_pkg::cnt_hold_done;
                data_ready  = 1'b1;
                next_state  = sipo_pkg::s_clear;   // next frame starts at once
            end
            default:
            begin
                next_state = sipo_pkg::s_clear;
            end
        endcase
    end

    // lanes and collector never see both strobes at once
    a_log_ready_excl: assert property (@(posedge clk) disable iff (!reset_b)
        !(data_logging && data_ready));

    // collector relies on a two-cycle ready level
    a_ready_two_cycles: assert property (@(posedge clk) disable iff (!reset_b)
        $rose(data_ready) |=> data_ready ##1 !data_ready);

endmodule

`default_nettype wire

//--- sipo_lane.sv
`timescale 1ns/1ps
`default_nettype none

module sipo_lane (
    input  logic                 clk,
    input  logic                 reset_b,
    input  logic                 serial_in,
    input  logic                 data_logging,
    output sipo_pkg::lane_word_t word
);

    // first bit of a frame ends up in the msb after 12 shifts
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
            word <= '0;
        else if (data_logging)
            word <= {word[sipo_pkg::frame_bits-2:0], serial_in};
    end

endmodule

`default_nettype wire

//--- frame_collector.sv
`timescale 1ns/1ps
`default_nettype none

module frame_collector (
    input  logic                                         clk,
    input  logic                                         reset_b,
    input  logic                                         data_ready,
    input  sipo_pkg::lane_word_t [sipo_pkg::n_lanes-1:0] lane_words,
    output sipo_pkg::frame_t                             frame,
    output logic                                         frame_valid
);

    logic                       ready_d;
    logic                       ready_rise;
    logic [sipo_pkg::seq_w-1:0] seq_cnt;

    assign ready_rise = data_ready && !ready_d;

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            ready_d     <= 1'b0;
            seq_cnt     <= '0;
            frame_valid <= 1'b0;
        end
        else
        begin
            ready_d     <= data_ready;
            frame_valid <= ready_rise;
            if (ready_rise)
                seq_cnt <= seq_cnt + 1'b1;   // wraps at 256
        end
    end

    // latched frame, held until the next ready rise
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
            frame <= '0;
        else if (ready_rise)
        begin
            frame.seq   <= seq_cnt;
            frame.words <= lane_words;
        end
    end

    a_valid_single: assert property (@(posedge clk) disable iff (!reset_b)
        frame_valid |=> !frame_valid);

endmodule

`default_nettype wire

//--- sipo_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module sipo_capture_top (
    input  logic                          clk,
    input  logic                          reset_b,
    input  logic [sipo_pkg::n_lanes-1:0]  serial_in,
    output sipo_pkg::frame_t              frame,
    output logic                          frame_valid
);

    logic [sipo_pkg::count_w-1:0]                 counter_value;
    sipo_pkg::cnt_sel_t                           counter_sel;
    logic                                         control_signal;
    logic                                         data_logging;
    logic                                         data_ready;
    sipo_pkg::lane_word_t [sipo_pkg::n_lanes-1:0] lane_words;

    sipo_controller u_controller (
        .clk            (clk),
        .reset_b        (reset_b),
        .counter_value  (counter_value),
        .counter_sel    (counter_sel),
        .control_signal (control_signal),
        .data_logging   (data_logging),
        .data_ready     (data_ready)
    );

    bit_counter u_counter (
        .clk            (clk),
        .reset_b        (reset_b),
        .counter_sel    (counter_sel),
        .control_signal (control_signal),
        .counter_value  (counter_value)
    );

    // one lane per serial input bit
    for (genvar g = 0; g < sipo_pkg::n_lanes; g++)
    begin : g_lane
        sipo_lane u_lane (
            .clk          (clk),
            .reset_b      (reset_b),
            .serial_in    (serial_in[g]),
            .data_logging (data_logging),
            .word         (lane_words[g])
        );
    end

    frame_collector u_collector (
        .clk         (clk),
        .reset_b     (reset_b),
        .data_ready  (data_ready),
        .lane_words  (lane_words),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

endmodule

`default_nettype wire

//--- tb_sipo_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sipo_capture;

    localparam int n_frames    = 36;
    localparam int n_words     = n_frames * sipo_pkg::n_lanes;
    localparam int log_first   = 3;                              // first logging cycle
    localparam int log_last    = log_first + sipo_pkg::frame_bits - 1;
    localparam int valid_index = sipo_pkg::frame_cycles - 1;     // frame_valid cycle
    localparam int abort_frame = 24;   // frame cut short by the second reset
    localparam int abort_index = 8;
    localparam int cycle_limit = n_frames * sipo_pkg::frame_cycles + 100;

    logic                         clk;
    logic                         reset_b;
    logic [sipo_pkg::n_lanes-1:0] serial_in;
    sipo_pkg::frame_t             frame;
    logic                         frame_valid;

    sipo_pkg::lane_word_t       stim_mem [0:n_words-1];
    sipo_pkg::frame_t           expected_frame;
    logic [sipo_pkg::seq_w-1:0] expected_seq;
    int                         seed;
    int                         cycle_count;

    sipo_capture_top dut (
        .clk         (clk),
        .reset_b     (reset_b),
        .serial_in   (serial_in),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
            report_failure($sformatf("timeout, test still running after %0d cycles",
                                     cycle_limit));
    end

    task report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task drive_random();
        int r;
        r = $random(seed);
        serial_in = r[sipo_pkg::n_lanes-1:0];
    endtask

    // msb of each word goes out in the first logging cycle
    task drive_lane_bits(input int f, input int idx);
        int l;
        if (idx >= log_first && idx <= log_last)
        begin
            for (l = 0; l < sipo_pkg::n_lanes; l++)
                serial_in[l] = stim_mem[f * sipo_pkg::n_lanes + l][log_last - idx];
        end
        else
            drive_random();   // padding must never reach a word
    endtask

    task check_outputs(input logic exp_valid);
        int l;
        assert (frame_valid === exp_valid)
        else report_failure($sformatf("FAIL frame_valid: expected %h, got %h (cycle %0d)",
                                      exp_valid, frame_valid, cycle_count));
        assert (frame.seq === expected_frame.seq)
        else report_failure($sformatf("FAIL frame.seq: expected %h, got %h",
                                      expected_frame.seq, frame.seq));
        for (l = 0; l < sipo_pkg::n_lanes; l++)
        begin
            assert (frame.words[l] === expected_frame.words[l])
            else report_failure($sformatf("FAIL frame.words[%0d]: expected %h, got %h",
                                          l, expected_frame.words[l], frame.words[l]));
        end
    endtask

    // drive one cycle, then look at the outputs of the next one
    task run_cycle(input int f, input int idx);
        int l;
        drive_lane_bits(f, idx);
        @(negedge clk);
        if (idx == valid_index - 1)
        begin
            // ready rose in this cycle, frame shows in the next
            expected_frame.seq = expected_seq;
            for (l = 0; l < sipo_pkg::n_lanes; l++)
                expected_frame.words[l] = stim_mem[f * sipo_pkg::n_lanes + l];
            expected_seq++;
            check_outputs(1'b1);
        end
        else
            check_outputs(1'b0);
    endtask

    task run_frame(input int f, input int n_cycles);
        int idx;
        for (idx = 0; idx < n_cycles; idx++)
            run_cycle(f, idx);
    endtask

    // two clock edges with reset_b low, released on a falling edge
    task apply_reset();
        reset_b        = 1'b0;
        expected_frame = '0;
        expected_seq   = '0;
        repeat (2)
        begin
            drive_random();
            @(negedge clk);
            check_outputs(1'b0);
        end
        reset_b = 1'b1;
    endtask

    initial
    begin
        int fd;
        int f;
        clk            = 1'b0;
        reset_b        = 1'b0;
        serial_in      = '0;
        seed           = 32'h3ca6_5127;
        cycle_count    = 0;
        expected_frame = '0;
        expected_seq   = '0;

        fd = $fopen("sipo_stim.txt", "r");
        assert (fd != 0)
        else report_failure("stimulus file sipo_stim.txt could not be opened");
        $fclose(fd);
        $readmemh("sipo_stim.txt", stim_mem);

        apply_reset();
        for (f = 0; f < abort_frame; f++)
            run_frame(f, sipo_pkg::frame_cycles);

        // reset again halfway through a frame
        run_frame(abort_frame, abort_index);
        apply_reset();
        for (f = abort_frame; f < n_frames; f++)
            run_frame(f, sipo_pkg::frame_cycles);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- sipo_stim.txt
// one frame per line: lane 0, lane 1, lane 2, lane 3
// each a 12-bit word in hex, sent msb first
3a7 c19 05e 9b2
f41 2d8 7c3 a06
16b e95 480 d3f
8c2 31d b7a 0f4
5e9 a63 c0b 27d
d18 4f6 913 eac
07d b84 2e1 6c5
a3f 15a f90 838
c6e 702 3b9 d57
291 ec8 64d 1a3
b5c 09f d26 7e0
4f3 8a1 1c7 f6a
e82 53b a9d 30c
6d4 c7f 058 b19
92a 1e6 e43 4b7
0b8 f2d 7a1 c94
7f1 46c b0e 2a9
c35 d9a 36f 81e
18d 6b3 fd2 e47
a60 247 89c 5fb
3ce 9e5 c14 07a
e19 5b0 6a8 d23
52b 83c 1f5 9d6
bd4 0e9 a72 643
26f c58 4ad fb1
f87 3a2 d61 1c9
849 e1b 57e b30
1b6 749 c83 2ed
d5a 9c0 03f 86b
60e f75 b92 4a4
a9b 26e e0d 7f8
477 bd1 395 c2c
// corner patterns: zeros, ones, alternating, walking one
000 000 000 000
fff fff fff fff
aaa 555 aaa 555
001 010 100 800

//--- sim.f
sipo_pkg.sv
bit_counter.sv
sipo_controller.sv
sipo_lane.sv
frame_collector.sv
sipo_capture_top.sv
tb_sipo_capture.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_sipo_capture -f sim.f -o tb_sipo_capture_sim \
    && ./obj_dir/tb_sipo_capture_sim > sim.log 2>&1 \
    || echo "build or run ended with an error"

cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log && echo "result: pass" && exit 0 \
    || { echo "result: fail"; exit 1; }
